/* compile.f */
source/vita_pkg.sv
source/settings_pkg.sv
source/vita_time_counter.sv
source/tx_strobe_gen.sv
source/tx_sample_fifo.sv
source/time_compare.sv
source/vita_tx_control.sv
source/vita_tx_top.sv
tb/tb_vita_tx.sv

/* Bender.yml */
package:
  name: vita_tx

sources:
  - files:
      - source/vita_pkg.sv
      - source/settings_pkg.sv
      - source/vita_time_counter.sv
      - source/tx_strobe_gen.sv
      - source/tx_sample_fifo.sv
      - source/time_compare.sv
      - source/vita_tx_control.sv
      - source/vita_tx_top.sv
  - target: test
    files:
      - tb/tb_vita_tx.sv

/* tb/tb_vita_tx.sv */
module tb_vita_tx
   import vita_pkg::*, settings_pkg::*;
();

   localparam int LEN_IMM    = 12;
   localparam int LEN_TIMED  = FIFO_DEPTH;  // Fills the queue while the burst waits
   localparam int LEN_STARVE = 10;
   localparam int LEN_RATE   = 12;
   localparam int MAX_RATE   = 7;
   localparam int TIMEOUT_CYCLES =
      (LEN_IMM + LEN_TIMED + 2 + LEN_STARVE + LEN_RATE) * (MAX_RATE + 1) + 2000;

   logic         clk;
   logic         arst_n_i;
   setting_bus_t set_bus_i;
   logic         push_i;
   tx_entry_t    entry_i;
   logic         full_o;
   sample_t      sample_o;
   logic         run_o;
   logic         strobe_o;
   logic         underrun_o;
   vita_time_t   vita_time_o;

   sample_t exp_q[$];
   sample_t exp_sample;
   bit      starve_ok = 1'b0;  // A dry strobe is legal only in the starvation test
   bit      starve_seen = 1'b0;
   int      cycle_cnt = 0;

   vita_tx_top dut (.*);

   always #20 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic stop_on_error(input string msg);
      $display("SIMULATION FAILED");
      $fatal(1, "%s", msg);
   endtask

   // Expected samples and end state of a burst whose head shows up at time t_head
   function automatic tx_state_e expect_burst(input tx_entry_t burst[$],
                                              input vita_time_t t_head,
                                              output sample_t samples[$]);
      samples = {};
      if (burst.size() == 0) return TX_IDLE;
      if (burst[0].send_at && burst[0].send_time != t_head) begin
         if (t_head > burst[0].send_time) return TX_UNDERRUN;
         if (burst[0].send_time - t_head > (64'd1 << 32)) return TX_UNDERRUN;
      end
      foreach (burst[i]) begin
         samples.push_back(burst[i].sample);
         if (burst[i].eop && burst[i].eob) return TX_IDLE;
      end
      return TX_UNDERRUN;  // Queue runs dry before the end of burst
   endfunction

   function automatic tx_entry_t make_entry(input logic send_at, input logic sob,
                                            input logic last, input logic with_eob,
                                            input vita_time_t send_time);
      tx_entry_t e;
      e.sample    = sample_t'($urandom);
      e.send_at   = send_at;
      e.sob       = sob;
      e.eop       = last;
      e.eob       = last && with_eob;
      e.send_time = send_time;
      return e;
   endfunction

   task automatic build_burst(input int len, input logic send_at, input vita_time_t send_time,
                              input logic with_eob, output tx_entry_t burst[$]);
      burst = {};
      for (int i = 0; i < len; i++) begin
         burst.push_back(make_entry(send_at && (i == 0), i == 0, i == len - 1, with_eob,
                                    send_time));
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      set_bus_i <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      set_bus_i.stb <= 1'b0;
   endtask

   task automatic push_burst(input tx_entry_t burst[$]);
      foreach (burst[i]) begin
         @(posedge clk);
         push_i  <= 1'b1;
         entry_i <= burst[i];
      end
      @(posedge clk);
      push_i <= 1'b0;
   endtask

   // Queues the reference samples, pushes the burst and returns the expected end state
   task automatic start_burst(input tx_entry_t burst[$], output tx_state_e final_state);
      sample_t samples[$];
      final_state = expect_burst(burst, vita_time_o, samples);
      foreach (samples[i]) exp_q.push_back(samples[i]);
      push_burst(burst);
   endtask

   task automatic wait_final(input tx_state_e final_state);
      do @(negedge clk);
      while (exp_q.size() != 0 || run_o || (final_state == TX_UNDERRUN && !underrun_o));
      assert (underrun_o == (final_state == TX_UNDERRUN))
         else stop_on_error($sformatf("mismatch underrun_o: got %h, expected %h (state %s)",
                                      underrun_o, final_state == TX_UNDERRUN,
                                      final_state.name()));
   endtask

   task automatic clear_and_check();
      write_setting(SR_TX_CLEAR, 32'h0);
      @(negedge clk);
      assert (!underrun_o)
         else stop_on_error($sformatf("mismatch underrun_o: got %h, expected 0", underrun_o));
      assert (!run_o)
         else stop_on_error($sformatf("mismatch run_o: got %h, expected 0", run_o));
   endtask

   task automatic check_strobe_spacing(input int rate);
      int gap;
      repeat (5) begin
         gap = 0;
         do begin
            @(negedge clk);
            gap++;
         end while (!strobe_o);
         assert (gap == rate + 1)
            else stop_on_error($sformatf("mismatch strobe_o gap: got %h, expected %h",
                                         gap, rate + 1));
      end
   endtask

   // DSP side takes one sample per strobe while running
   always @(negedge clk) begin
      if (arst_n_i && strobe_o && run_o) begin
         if (exp_q.size() == 0) begin
            assert (starve_ok) else stop_on_error("DSP strobe in a burst with no sample queued");
            starve_seen = 1'b1;
         end else begin
            exp_sample = exp_q.pop_front();
            assert (sample_o == exp_sample)
               else stop_on_error($sformatf("mismatch sample_o: got %h, expected %h",
                                            sample_o, exp_sample));
         end
      end
   end

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Run did not finish within %0d cycles", TIMEOUT_CYCLES);
   end

   initial begin
      tx_entry_t   burst[$];
      tx_state_e   final_state;
      vita_time_t  t_now;
      vita_time_t  send_time;
      logic [31:0] hi;
      logic [31:0] lo;
      int          rate;
      void'($urandom(32'h73395773));
      clk       = 1'b0;
      arst_n_i  = 1'b0;
      set_bus_i = '0;
      push_i    = 1'b0;
      entry_i   = '0;
      repeat (2) @(posedge clk);
      arst_n_i <= 1'b1;

      build_burst(LEN_IMM, 1'b0, 64'd0, 1'b1, burst);
      start_burst(burst, final_state);
      wait_final(final_state);

      hi = $urandom & 32'h7fff_ffff;  // Keeps the far triggers from wrapping
      lo = $urandom;
      write_setting(SR_TIME_HI, hi);
      write_setting(SR_TIME_LO, lo);
      @(negedge clk);
      assert (vita_time_o == {hi, lo})
         else stop_on_error($sformatf("mismatch vita_time_o: got %h, expected %h",
                                      vita_time_o, {hi, lo}));
      send_time = vita_time_o + 64'd50;
      build_burst(LEN_TIMED, 1'b1, send_time, 1'b1, burst);
      start_burst(burst, final_state);
      @(negedge clk);
      assert (full_o)
         else stop_on_error($sformatf("mismatch full_o: got %h, expected 1", full_o));
      while (vita_time_o != send_time) begin
         assert (!run_o) else stop_on_error("mismatch run_o: got 1, expected 0");
         @(negedge clk);
      end
      assert (!run_o) else stop_on_error("mismatch run_o: got 1, expected 0");
      @(negedge clk);
      assert (run_o) else stop_on_error("mismatch run_o: got 0, expected 1");
      wait_final(final_state);

      @(negedge clk);
      t_now = vita_time_o;
      build_burst(1, 1'b1, t_now - 64'd100, 1'b1, burst);
      start_burst(burst, final_state);
      wait_final(final_state);
      clear_and_check();
      t_now = vita_time_o;
      build_burst(1, 1'b1, t_now + (64'd1 << 33), 1'b1, burst);
      start_burst(burst, final_state);
      wait_final(final_state);
      clear_and_check();

      starve_ok = 1'b1;
      build_burst(LEN_STARVE, 1'b0, 64'd0, 1'b0, burst);
      start_burst(burst, final_state);
      wait_final(final_state);
      assert (starve_seen) else stop_on_error("queue never ran dry on a strobe");
      repeat (20) begin
         @(negedge clk);
         assert (underrun_o) else stop_on_error("mismatch underrun_o: got 0, expected 1");
      end
      clear_and_check();
      starve_ok = 1'b0;

      rate = $urandom_range(MAX_RATE, 1);
      write_setting(SR_STROBE_RATE, rate);
      check_strobe_spacing(rate);
      build_burst(LEN_RATE, 1'b0, 64'd0, 1'b1, burst);
      start_burst(burst, final_state);
      wait_final(final_state);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* source/vita_tx_top.sv */
module vita_tx_top
   import vita_pkg::*, settings_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n_i,
   input  setting_bus_t set_bus_i,
   input  logic         push_i,
   input  tx_entry_t    entry_i,
   output logic         full_o,
   output sample_t      sample_o,
   output logic         run_o,
   output logic         strobe_o,
   output logic         underrun_o,
   output vita_time_t   vita_time_o
);

   tx_entry_t head;
   logic      valid;
   logic      pop;
   logic      flush;
   logic      now;
   logic      late;
   logic      too_early;

   vita_time_counter u_time (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .set_bus_i   (set_bus_i),
      .vita_time_o (vita_time_o)
   );

   tx_strobe_gen u_strobe (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .set_bus_i (set_bus_i),
      .strobe_o  (strobe_o)
   );

   tx_sample_fifo u_fifo (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .push_i   (push_i),
      .entry_i  (entry_i),
      .pop_i    (pop),
      .flush_i  (flush),
      .head_o   (head),
      .valid_o  (valid),
      .full_o   (full_o)
   );

   time_compare u_cmp (
      .time_now_i     (vita_time_o),
      .trigger_time_i (head.send_time),
      .now_o          (now),
      .early_o        (),  // Control only needs to know when waiting is over
      .late_o         (late),
      .too_early_o    (too_early)
   );

   vita_tx_control u_ctrl (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .set_bus_i   (set_bus_i),
      .head_i      (head),
      .valid_i     (valid),
      .now_i       (now),
      .late_i      (late),
      .too_early_i (too_early),
      .strobe_i    (strobe_o),
      .pop_o       (pop),
      .flush_o     (flush),
      .run_o       (run_o),
      .underrun_o  (underrun_o)
   );

   assign sample_o = head.sample;

endmodule

/* source/vita_tx_control.sv */
module vita_tx_control
   import vita_pkg::*, settings_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n_i,
   input  setting_bus_t set_bus_i,
   input  tx_entry_t    head_i,
   input  logic         valid_i,
   input  logic         now_i,
   input  logic         late_i,
   input  logic         too_early_i,
   input  logic         strobe_i,
   output logic         pop_o,
   output logic         flush_o,
   output logic         run_o,
   output logic         underrun_o
);

   tx_state_e state;
   logic      clear;

   // Clear also empties the queue so a stale burst cannot restart
   assign clear   = set_bus_i.stb && (set_bus_i.addr == SR_TX_CLEAR);
   assign flush_o = clear;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= TX_IDLE;
      end else if (clear) begin
         state <= TX_IDLE;
      end else begin
         case (state)
            TX_IDLE: begin
               if (valid_i) begin
                  if (!head_i.send_at || now_i) begin
                     state <= TX_RUN;
                  end else if (late_i || too_early_i) begin
                     state <= TX_UNDERRUN;
                  end
               end
            end
            TX_RUN: begin
               if (strobe_i) begin
                  if (!valid_i) begin
                     state <= TX_UNDERRUN;  // Queue ran dry inside a burst
                  end else if (head_i.eop && head_i.eob) begin
                     state <= TX_IDLE;
                  end
               end
            end
            TX_UNDERRUN: begin
               state <= TX_UNDERRUN;  // Sticky until the host clears it
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   assign pop_o      = (state == TX_RUN) && strobe_i && valid_i;
   assign run_o      = (state == TX_RUN);
   assign underrun_o = (state == TX_UNDERRUN);

endmodule

/* source/time_compare.sv */
module time_compare
   import vita_pkg::*;
(
   input  vita_time_t time_now_i,
   input  vita_time_t trigger_time_i,
   output logic       now_o,
   output logic       early_o,
   output logic       late_o,
   output logic       too_early_o
);

   vita_time_t lead;  // How far the trigger sits ahead of now

   assign lead = trigger_time_i - time_now_i;

   assign now_o   = (time_now_i == trigger_time_i);
   assign late_o  = (time_now_i > trigger_time_i);
   assign early_o = (trigger_time_i > time_now_i);

   // Only meaningful while early since the lead wraps when late
   assign too_early_o = early_o && (lead > (vita_time_t'(1) << TOO_EARLY_SHIFT));

endmodule

/* source/tx_sample_fifo.sv */
module tx_sample_fifo
   import vita_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n_i,
   input  logic      push_i,
   input  tx_entry_t entry_i,
   input  logic      pop_i,
   input  logic      flush_i,
   output tx_entry_t head_o,
   output logic      valid_o,
   output logic      full_o
);

   tx_entry_t mem [FIFO_DEPTH];

   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  do_push;
   logic                  do_pop;

   // Flush takes priority over anything else in the same cycle
   assign do_push = push_i && !full_o && !flush_i;
   assign do_pop  = pop_i && valid_o && !flush_i;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= entry_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps on its own at a power-of-two depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Show-ahead output
   assign head_o  = mem[rd_ptr];
   assign valid_o = (count != '0);
   assign full_o  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      pop_i |-> valid_o
   );

   a_no_push_full: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      push_i |-> !full_o
   );

endmodule

/* source/tx_strobe_gen.sv */
module tx_strobe_gen
   import settings_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n_i,
   input  setting_bus_t set_bus_i,
   output logic         strobe_o
);

   logic [31:0] rate;
   logic [31:0] count;
   logic        rate_wr;

   assign rate_wr = set_bus_i.stb && (set_bus_i.addr == SR_STROBE_RATE);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rate  <= '0;
         count <= '0;
      end else if (rate_wr) begin
         rate  <= set_bus_i.data;
         count <= set_bus_i.data;  // Restart so the first strobe lands rate+1 cycles out
      end else if (count == '0) begin
         count <= rate;
      end else begin
         count <= count - 32'd1;
      end
   end

   assign strobe_o = (count == '0);

   // Back to back strobes only make sense when every cycle is a strobe
   a_strobe_spacing: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      strobe_o && $past(strobe_o) |-> rate == '0
   );

endmodule

/* source/vita_time_counter.sv */
module vita_time_counter
   import vita_pkg::*, settings_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n_i,
   input  setting_bus_t set_bus_i,
   output vita_time_t   vita_time_o
);

   logic [31:0] time_hi;
   logic        time_hi_wr;
   logic        time_lo_wr;

   assign time_hi_wr = set_bus_i.stb && (set_bus_i.addr == SR_TIME_HI);
   assign time_lo_wr = set_bus_i.stb && (set_bus_i.addr == SR_TIME_LO);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         time_hi <= '0;
      end else if (time_hi_wr) begin
         time_hi <= set_bus_i.data;
      end
   end

   // The low word write commits both halves at once so the time never tears
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         vita_time_o <= '0;
      end else if (time_lo_wr) begin
         vita_time_o <= {time_hi, set_bus_i.data};
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

endmodule

/* source/settings_pkg.sv */
package settings_pkg;

   // Single-cycle register write from the host side
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } setting_bus_t;

   localparam logic [7:0] SR_TIME_HI     = 8'h10;  // Staged until the low word arrives
   localparam logic [7:0] SR_TIME_LO     = 8'h11;
   localparam logic [7:0] SR_STROBE_RATE = 8'h12;  // Divider minus one
   localparam logic [7:0] SR_TX_CLEAR    = 8'h13;

endpackage

/* source/vita_pkg.sv */
package vita_pkg;

   // Radio time in clock ticks
   typedef logic [63:0] vita_time_t;

   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } sample_t;

   // One queued transmit entry, sample on top and send time at the bottom
   typedef struct packed {
      sample_t    sample;
      logic       send_at;  // Hold the burst until send_time
      logic       sob;
      logic       eob;
      logic       eop;
      vita_time_t send_time;
   } tx_entry_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_RUN,
      TX_UNDERRUN
   } tx_state_e;

   // Triggers further ahead than 2**TOO_EARLY_SHIFT ticks are rejected
   localparam int TOO_EARLY_SHIFT = 32;

   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);  // Depth must be a power of two

endpackage
